// File: common/tapc_defs.svh
// Instruction codes and channel ids follow the RISC-V debug DTM map; TAPC_IR_WIDTH must stay 5
`ifndef TAPC_DEFS_SVH
`define TAPC_DEFS_SVH

// Instruction register
`define TAPC_IR_WIDTH          5
`define TAPC_INSTR_IDCODE      5'h01
`define TAPC_INSTR_BYPASS      5'h1F
`define TAPC_INSTR_DTMCS       5'h10
`define TAPC_INSTR_DMI_ACCESS  5'h11
`define TAPC_INSTR_BLD_ID      5'h04
`define TAPC_INSTR_SCU_ACCESS  5'h09

// Data registers
`define TAPC_IDCODE_WIDTH      32
`define TAPC_BLD_ID_WIDTH      32
`define TAPC_BLD_ID_VALUE      32'h4254_0101

// External chain ids, SCU uses zero
`define TAPC_CH_ID_WIDTH       2
`define TAPC_CH_ID_DTMCS       2'd1
`define TAPC_CH_ID_DMI         2'd2

`endif

// File: common/tapc_pkg.sv
// Types only; the include path must reach common/ so tapc_defs.svh resolves
`include "tapc_defs.svh"

package tapc_pkg;

    // IEEE 1149.1 TAP states, all sixteen four-bit codes used
    typedef enum logic [3:0] {
        TAP_TLR,
        TAP_RTI,
        TAP_SEL_DR,
        TAP_CAP_DR,
        TAP_SHIFT_DR,
        TAP_EX1_DR,
        TAP_PAUSE_DR,
        TAP_EX2_DR,
        TAP_UPD_DR,
        TAP_SEL_IR,
        TAP_CAP_IR,
        TAP_SHIFT_IR,
        TAP_EX1_IR,
        TAP_PAUSE_IR,
        TAP_EX2_IR,
        TAP_UPD_IR
    } tap_state_e;

    typedef logic [`TAPC_IR_WIDTH-1:0]     tapc_ir_t;
    typedef logic [`TAPC_IDCODE_WIDTH-1:0] tapc_idcode_t;
    typedef logic [`TAPC_BLD_ID_WIDTH-1:0] tapc_bld_id_t;
    typedef logic [`TAPC_CH_ID_WIDTH-1:0]  tapc_ch_id_t;

endpackage

// File: common/tapc_dr_ctrl_if.sv
// Level strobes valid for one TCK period per state; no handshake, the host paces with TMS
`timescale 1ns/100ps

interface tapc_dr_ctrl_if;

    logic sync_rst_n;   // Low while in Test-Logic-Reset, falling-edge timed
    logic dr_capture;
    logic dr_shift;
    logic dr_update;
    logic ir_capture;
    logic ir_shift;
    logic ir_update;
    logic tdi;          // TDI pin, passed through

    // State machine side
    modport fsm_mp (output sync_rst_n, dr_capture, dr_shift, dr_update,
                    output ir_capture, ir_shift, ir_update, tdi);

    // Register blocks
    modport reg_mp (input sync_rst_n, dr_capture, dr_shift, dr_update,
                    input ir_capture, ir_shift, ir_update, tdi);

endinterface

// File: source/tapc_dr_shift_reg.sv
// LSB-first capture and shift register; contents are held whenever it is not selected
`timescale 1ns/100ps

module tapc_dr_shift_reg #(
    parameter int WIDTH = 32
) (
    input  logic             tapc_tck,
    input  logic             tapc_trst_n,
    input  logic             sync_rst_n_i,
    input  logic             sel_i,
    input  logic             capture_i,
    input  logic             shift_i,
    input  logic             tdi_i,
    input  logic [WIDTH-1:0] din_i,
    output logic             tdo_o
);

    logic [WIDTH-1:0] shift_q;
    logic [WIDTH-1:0] shift_nxt;

    // Shift right, TDI in at the top; also covers WIDTH of 1
    always_comb begin
        shift_nxt            = shift_q >> 1;
        shift_nxt[WIDTH-1]   = tdi_i;
    end

    always_ff @(posedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            shift_q <= '0;
        end else if (!sync_rst_n_i) begin
            shift_q <= '0;
        end else if (sel_i && capture_i) begin
            shift_q <= din_i;
        end else if (sel_i && shift_i) begin
            shift_q <= shift_nxt;
        end
    end

    assign tdo_o = shift_q[0];

endmodule

// File: tapc_fsm/tapc_fsm.sv
// TMS sampled on rising TCK; strobes are registered from the next state, so no decode glitches
`timescale 1ns/100ps

module tapc_fsm (
    input  logic           tapc_tck,
    input  logic           tapc_trst_n,
    input  logic           tms_i,
    input  logic           tdi_i,
    tapc_dr_ctrl_if.fsm_mp ctrl
);

    tapc_pkg::tap_state_e state_q;
    tapc_pkg::tap_state_e state_d;
    logic                 sync_rst_n_q;
    // {dr_capture, dr_shift, dr_update, ir_capture, ir_shift, ir_update}
    logic [5:0]           strobe_q;
    logic [5:0]           strobe_d;

    // ------------------------------------------------------------------
    // State register and transition table
    // ------------------------------------------------------------------
    always_ff @(posedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= tapc_pkg::TAP_TLR;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            tapc_pkg::TAP_TLR:
                state_d = tms_i ? tapc_pkg::TAP_TLR : tapc_pkg::TAP_RTI;
            tapc_pkg::TAP_RTI:
                state_d = tms_i ? tapc_pkg::TAP_SEL_DR : tapc_pkg::TAP_RTI;
            tapc_pkg::TAP_SEL_DR:
                state_d = tms_i ? tapc_pkg::TAP_SEL_IR : tapc_pkg::TAP_CAP_DR;
            tapc_pkg::TAP_CAP_DR:
                state_d = tms_i ? tapc_pkg::TAP_EX1_DR : tapc_pkg::TAP_SHIFT_DR;
            tapc_pkg::TAP_SHIFT_DR:
                state_d = tms_i ? tapc_pkg::TAP_EX1_DR : tapc_pkg::TAP_SHIFT_DR;
            tapc_pkg::TAP_EX1_DR:
                state_d = tms_i ? tapc_pkg::TAP_UPD_DR : tapc_pkg::TAP_PAUSE_DR;
            tapc_pkg::TAP_PAUSE_DR:
                state_d = tms_i ? tapc_pkg::TAP_EX2_DR : tapc_pkg::TAP_PAUSE_DR;
            tapc_pkg::TAP_EX2_DR:
                state_d = tms_i ? tapc_pkg::TAP_UPD_DR : tapc_pkg::TAP_SHIFT_DR;
            tapc_pkg::TAP_UPD_DR:
                state_d = tms_i ? tapc_pkg::TAP_SEL_DR : tapc_pkg::TAP_RTI;
            tapc_pkg::TAP_SEL_IR:
                state_d = tms_i ? tapc_pkg::TAP_TLR : tapc_pkg::TAP_CAP_IR;
            tapc_pkg::TAP_CAP_IR:
                state_d = tms_i ? tapc_pkg::TAP_EX1_IR : tapc_pkg::TAP_SHIFT_IR;
            tapc_pkg::TAP_SHIFT_IR:
                state_d = tms_i ? tapc_pkg::TAP_EX1_IR : tapc_pkg::TAP_SHIFT_IR;
            tapc_pkg::TAP_EX1_IR:
                state_d = tms_i ? tapc_pkg::TAP_UPD_IR : tapc_pkg::TAP_PAUSE_IR;
            tapc_pkg::TAP_PAUSE_IR:
                state_d = tms_i ? tapc_pkg::TAP_EX2_IR : tapc_pkg::TAP_PAUSE_IR;
            tapc_pkg::TAP_EX2_IR:
                state_d = tms_i ? tapc_pkg::TAP_UPD_IR : tapc_pkg::TAP_SHIFT_IR;
            tapc_pkg::TAP_UPD_IR:
                state_d = tms_i ? tapc_pkg::TAP_SEL_DR : tapc_pkg::TAP_RTI;
            // Unreachable code holds where it is
            default:
                state_d = state_q;
        endcase
    end

    // ------------------------------------------------------------------
    // Synchronous reset, half a cycle after entering Test-Logic-Reset
    // ------------------------------------------------------------------
    always_ff @(negedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            sync_rst_n_q <= 1'b0;
        end else begin
            sync_rst_n_q <= (state_q != tapc_pkg::TAP_TLR);
        end
    end

    // Strobes lead by one decode, land exactly on their state
    assign strobe_d = {state_d == tapc_pkg::TAP_CAP_DR,   state_d == tapc_pkg::TAP_SHIFT_DR,
                       state_d == tapc_pkg::TAP_UPD_DR,   state_d == tapc_pkg::TAP_CAP_IR,
                       state_d == tapc_pkg::TAP_SHIFT_IR, state_d == tapc_pkg::TAP_UPD_IR};

    always_ff @(posedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            strobe_q <= '0;
        end else if (!sync_rst_n_q) begin
            strobe_q <= '0;
        end else begin
            strobe_q <= strobe_d;
        end
    end

    assign ctrl.sync_rst_n = sync_rst_n_q;
    assign {ctrl.dr_capture, ctrl.dr_shift, ctrl.dr_update,
            ctrl.ir_capture, ctrl.ir_shift, ctrl.ir_update} = strobe_q;
    assign ctrl.tdi        = tdi_i;

    // All sixteen codes are legal, so only an unknown state can leave the table
    a_state_legal : assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        !$isunknown(state_q))
        else $error("tapc_fsm: TAP state left the legal set");

    a_pins_known : assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        !$isunknown({tms_i, tdi_i}))
        else $error("tapc_fsm: TMS or TDI unknown");

endmodule

// File: tapc_ir/tapc_ir.sv
// Unknown instruction codes fall back to BYPASS; IR reverts to IDCODE on either reset
`timescale 1ns/100ps
`include "tapc_defs.svh"

module tapc_ir (
    input  logic                  tapc_tck,
    input  logic                  tapc_trst_n,
    tapc_dr_ctrl_if.reg_mp        ctrl,
    output logic                  idcode_sel_o,
    output logic                  bypass_sel_o,
    output logic                  bld_id_sel_o,
    output logic                  dmi_ch_sel_o,
    output logic                  scu_ch_sel_o,
    output tapc_pkg::tapc_ch_id_t ch_id_o,
    output logic                  ir_tdo_o
);

    tapc_pkg::tapc_ir_t ir_shift_q;
    tapc_pkg::tapc_ir_t ir_q;

    // ------------------------------------------------------------------
    // Instruction shift register, rising edge
    // ------------------------------------------------------------------
    always_ff @(posedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q <= '0;
        end else if (!ctrl.sync_rst_n) begin
            ir_shift_q <= '0;
        end else if (ctrl.ir_capture) begin
            // Fixed 00001 capture pattern
            ir_shift_q <= tapc_pkg::tapc_ir_t'(1);
        end else if (ctrl.ir_shift) begin
            ir_shift_q <= {ctrl.tdi, ir_shift_q[`TAPC_IR_WIDTH-1:1]};
        end
    end

    assign ir_tdo_o = ir_shift_q[0];

    // Instruction register, falling edge in Update-IR
    always_ff @(negedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_q <= `TAPC_INSTR_IDCODE;
        end else if (!ctrl.sync_rst_n) begin
            ir_q <= `TAPC_INSTR_IDCODE;
        end else if (ctrl.ir_update) begin
            ir_q <= ir_shift_q;
        end
    end

    // ------------------------------------------------------------------
    // Instruction decode
    // ------------------------------------------------------------------
    always_comb begin
        idcode_sel_o = 1'b0;
        bypass_sel_o = 1'b0;
        bld_id_sel_o = 1'b0;
        dmi_ch_sel_o = 1'b0;
        scu_ch_sel_o = 1'b0;
        ch_id_o      = '0;
        case (ir_q)
            `TAPC_INSTR_DTMCS: begin
                dmi_ch_sel_o = 1'b1;
                ch_id_o      = `TAPC_CH_ID_DTMCS;
            end
            `TAPC_INSTR_DMI_ACCESS: begin
                dmi_ch_sel_o = 1'b1;
                ch_id_o      = `TAPC_CH_ID_DMI;
            end
            `TAPC_INSTR_SCU_ACCESS: scu_ch_sel_o = 1'b1;
            `TAPC_INSTR_IDCODE:     idcode_sel_o = 1'b1;
            `TAPC_INSTR_BLD_ID:     bld_id_sel_o = 1'b1;
            // Explicit BYPASS and every unused code
            default:                bypass_sel_o = 1'b1;
        endcase
    end

    // DR bank mux and chain pins rely on a single owner of TDO
    a_sel_onehot : assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        $onehot0({idcode_sel_o, bypass_sel_o, bld_id_sel_o, dmi_ch_sel_o, scu_ch_sel_o}))
        else $error("tapc_ir: more than one data register selected");

endmodule

// File: source/tapc_dr_bank.sv
// Internal DRs plus the pin TDO stage; external chain data must be valid by falling TCK
`timescale 1ns/100ps
`include "tapc_defs.svh"

module tapc_dr_bank (
    input  logic                   tapc_tck,
    input  logic                   tapc_trst_n,
    tapc_dr_ctrl_if.reg_mp         ctrl,
    input  tapc_pkg::tapc_idcode_t fuse_idcode_i,
    input  logic                   idcode_sel_i,
    input  logic                   bypass_sel_i,
    input  logic                   bld_id_sel_i,
    input  logic                   dmi_ch_sel_i,
    input  logic                   scu_ch_sel_i,
    input  logic                   ir_tdo_i,
    input  logic                   ch_tdo_i,
    output logic                   tdo_o,
    output logic                   tdo_en_o
);

    logic bypass_tdo;
    logic idcode_tdo;
    logic bld_id_tdo;
    logic dr_out;
    logic tdo_q;
    logic tdo_en_q;

    // ------------------------------------------------------------------
    // Data registers
    // ------------------------------------------------------------------

    // Mandatory 1149.1 bypass, captures 0
    tapc_dr_shift_reg #(.WIDTH(1)) u_bypass (
        .tapc_tck (tapc_tck), .tapc_trst_n (tapc_trst_n), .sync_rst_n_i (ctrl.sync_rst_n),
        .sel_i    (bypass_sel_i), .capture_i (ctrl.dr_capture), .shift_i (ctrl.dr_shift),
        .tdi_i    (ctrl.tdi), .din_i (1'b0), .tdo_o (bypass_tdo)
    );

    // Device id straight from fuses
    tapc_dr_shift_reg #(.WIDTH(`TAPC_IDCODE_WIDTH)) u_idcode (
        .tapc_tck (tapc_tck), .tapc_trst_n (tapc_trst_n), .sync_rst_n_i (ctrl.sync_rst_n),
        .sel_i    (idcode_sel_i), .capture_i (ctrl.dr_capture), .shift_i (ctrl.dr_shift),
        .tdi_i    (ctrl.tdi), .din_i (fuse_idcode_i), .tdo_o (idcode_tdo)
    );

    // Build id constant
    tapc_dr_shift_reg #(.WIDTH(`TAPC_BLD_ID_WIDTH)) u_bld_id (
        .tapc_tck (tapc_tck), .tapc_trst_n (tapc_trst_n), .sync_rst_n_i (ctrl.sync_rst_n),
        .sel_i    (bld_id_sel_i), .capture_i (ctrl.dr_capture), .shift_i (ctrl.dr_shift),
        .tdi_i    (ctrl.tdi), .din_i (tapc_pkg::tapc_bld_id_t'(`TAPC_BLD_ID_VALUE)),
        .tdo_o    (bld_id_tdo)
    );

    // Read mux, selects are one-hot from the decoder
    assign dr_out = (idcode_sel_i & idcode_tdo)
                  | (bypass_sel_i & bypass_tdo)
                  | (bld_id_sel_i & bld_id_tdo)
                  | ((dmi_ch_sel_i | scu_ch_sel_i) & ch_tdo_i);

    // ------------------------------------------------------------------
    // TDO pin stage, falling edge
    // ------------------------------------------------------------------
    always_ff @(negedge tapc_tck, negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else if (!ctrl.sync_rst_n) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else begin
            tdo_q    <= ctrl.dr_shift ? dr_out : (ctrl.ir_shift & ir_tdo_i);
            tdo_en_q <= ctrl.dr_shift | ctrl.ir_shift;
        end
    end

    assign tdo_o    = tdo_q;
    assign tdo_en_o = tdo_en_q;

    // Pin is driven only in the half cycle after a shift-state falling edge
    a_tdo_en_shift : assert property (@(negedge tapc_tck) disable iff (!tapc_trst_n)
        tdo_en_o |-> $past(ctrl.dr_shift || ctrl.ir_shift))
        else $error("tapc_dr_bank: TDO enabled outside a shift state");

    a_ch_tdo_known : assert property (@(negedge tapc_tck) disable iff (!tapc_trst_n)
        ctrl.dr_shift |-> !$isunknown(ch_tdo_i))
        else $error("tapc_dr_bank: chain TDO unknown in Shift-DR");

endmodule

// File: source/tapc.sv
// JTAG TAP top; TDO and TDO enable change on falling TCK, chain strobes on rising TCK
`timescale 1ns/100ps

module tapc (
    // JTAG pins
    input  logic                   tapc_tck,
    input  logic                   tapc_trst_n,
    input  logic                   tms_i,
    input  logic                   tdi_i,
    output logic                   tdo_o,
    output logic                   tdo_en_o,
    // Device id from fuses
    input  tapc_pkg::tapc_idcode_t fuse_idcode_i,
    // DMI and SCU scan chains
    output logic                   dmi_ch_sel_o,
    output logic                   scu_ch_sel_o,
    output tapc_pkg::tapc_ch_id_t  ch_id_o,
    output logic                   ch_capture_o,
    output logic                   ch_shift_o,
    output logic                   ch_update_o,
    output logic                   ch_tdi_o,
    input  logic                   ch_tdo_i
);

    tapc_dr_ctrl_if ctrl_if ();

    // Decoded selects from the instruction register
    logic idcode_sel;
    logic bypass_sel;
    logic bld_id_sel;
    logic ir_tdo;

    tapc_fsm u_fsm (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tms_i       (tms_i),
        .tdi_i       (tdi_i),
        .ctrl        (ctrl_if)
    );

    tapc_ir u_ir (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .ctrl         (ctrl_if),
        .idcode_sel_o (idcode_sel),
        .bypass_sel_o (bypass_sel),
        .bld_id_sel_o (bld_id_sel),
        .dmi_ch_sel_o (dmi_ch_sel_o),
        .scu_ch_sel_o (scu_ch_sel_o),
        .ch_id_o      (ch_id_o),
        .ir_tdo_o     (ir_tdo)
    );

    tapc_dr_bank u_dr_bank (
        .tapc_tck      (tapc_tck),
        .tapc_trst_n   (tapc_trst_n),
        .ctrl          (ctrl_if),
        .fuse_idcode_i (fuse_idcode_i),
        .idcode_sel_i  (idcode_sel),
        .bypass_sel_i  (bypass_sel),
        .bld_id_sel_i  (bld_id_sel),
        .dmi_ch_sel_i  (dmi_ch_sel_o),
        .scu_ch_sel_i  (scu_ch_sel_o),
        .ir_tdo_i      (ir_tdo),
        .ch_tdo_i      (ch_tdo_i),
        .tdo_o         (tdo_o),
        .tdo_en_o      (tdo_en_o)
    );

    // Chains see the DR strobes and raw TDI
    assign ch_capture_o = ctrl_if.dr_capture;
    assign ch_shift_o   = ctrl_if.dr_shift;
    assign ch_update_o  = ctrl_if.dr_update;
    assign ch_tdi_o     = ctrl_if.tdi;

endmodule

// File: sim/tapc_tb.sv
// Needs a simulator with timing support; every DR scan is 32 bits, LSB first, one bit per TCK
`timescale 1ns/100ps
`include "tapc_defs.svh"

module tapc_tb;

    // Scan budget: reset, 8 DR scans, 6 IR scans and a few idle steps, doubled
    localparam int SCAN_CYCLES = 16 + 8 * (32 + 6) + 6 * (`TAPC_IR_WIDTH + 8) + 12;
    localparam int CYCLE_LIMIT = 2 * SCAN_CYCLES;

    logic                   tapc_tck = 1'b0;
    logic                   tapc_trst_n;
    logic                   tms_i;
    logic                   tdi_i;
    logic                   ch_tdo_i;
    tapc_pkg::tapc_idcode_t fuse_idcode_i;
    logic                   tdo_o;
    logic                   tdo_en_o;
    logic                   dmi_ch_sel_o;
    logic                   scu_ch_sel_o;
    tapc_pkg::tapc_ch_id_t  ch_id_o;
    logic                   ch_capture_o;
    logic                   ch_shift_o;
    logic                   ch_update_o;
    logic                   ch_tdi_o;

    integer             seed = 32'hd271;
    int                 scan_errors = 0;
    int                 pin_errors = 0;
    int                 cycle_count = 0;
    logic               exp_en = 1'b0;  // TDO enable expected at the coming rising edge
    logic               tdo_seen;       // TDO as sampled on the last rising edge
    tapc_pkg::tapc_ir_t cur_instr;

    tapc tapc_i (
        .tapc_tck      (tapc_tck),
        .tapc_trst_n   (tapc_trst_n),
        .tms_i         (tms_i),
        .tdi_i         (tdi_i),
        .tdo_o         (tdo_o),
        .tdo_en_o      (tdo_en_o),
        .fuse_idcode_i (fuse_idcode_i),
        .dmi_ch_sel_o  (dmi_ch_sel_o),
        .scu_ch_sel_o  (scu_ch_sel_o),
        .ch_id_o       (ch_id_o),
        .ch_capture_o  (ch_capture_o),
        .ch_shift_o    (ch_shift_o),
        .ch_update_o   (ch_update_o),
        .ch_tdi_o      (ch_tdi_o),
        .ch_tdo_i      (ch_tdo_i)
    );

    always #2 tapc_tck = ~tapc_tck;

    // ------------------------------------------------------------------
    // Compare tasks and reference model
    // ------------------------------------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act,
                             inout int errors);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idcode(input string name, input tapc_pkg::tapc_idcode_t exp,
                                input tapc_pkg::tapc_idcode_t act, inout int errors);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ch_id(input string name, input tapc_pkg::tapc_ch_id_t exp,
                               input tapc_pkg::tapc_ch_id_t act, inout int errors);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_ir(input string name, input tapc_pkg::tapc_ir_t exp,
                            input tapc_pkg::tapc_ir_t act, inout int errors);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Expected 32-bit DR scan-out for the current instruction
    function automatic tapc_pkg::tapc_idcode_t expected_dr_value(
        input tapc_pkg::tapc_ir_t instr, input tapc_pkg::tapc_idcode_t fuse,
        input logic [31:0] tdi_bits, input logic [31:0] ch_bits);
        case (instr)
            `TAPC_INSTR_IDCODE:     return fuse;
            `TAPC_INSTR_BLD_ID:     return `TAPC_BLD_ID_VALUE;
            `TAPC_INSTR_DTMCS:      return ch_bits;
            `TAPC_INSTR_DMI_ACCESS: return ch_bits;
            `TAPC_INSTR_SCU_ACCESS: return ch_bits;
            // Bypass: captured 0, then TDI one bit late
            default:                return {tdi_bits[30:0], 1'b0};
        endcase
    endfunction

    // ------------------------------------------------------------------
    // JTAG driver
    // ------------------------------------------------------------------
    // Starts 1 ns after a rising edge, ends 1 ns after the next one
    task automatic tck_step(input logic tms, input logic tdi, input logic ch_tdo,
                            input logic en_exp);
        tms_i    = tms;
        tdi_i    = tdi;
        ch_tdo_i = ch_tdo;
        exp_en   = en_exp;
        @(posedge tapc_tck);
        tdo_seen = tdo_o;
        #1;
    endtask

    // Five TMS highs reach Test-Logic-Reset from anywhere, then idle
    task automatic reset_to_idle();
        repeat (5) tck_step(1'b1, 1'b0, 1'b0, 1'b0);
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);
        cur_instr = `TAPC_INSTR_IDCODE;
    endtask

    task automatic ir_scan(input tapc_pkg::tapc_ir_t code, output tapc_pkg::tapc_ir_t captured);
        int i;
        tck_step(1'b1, 1'b0, 1'b0, 1'b0);   // Select-DR
        tck_step(1'b1, 1'b0, 1'b0, 1'b0);   // Select-IR
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Capture-IR
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Shift-IR
        for (i = 0; i < `TAPC_IR_WIDTH; i++) begin
            tck_step(i == `TAPC_IR_WIDTH - 1, code[i], 1'b0, 1'b1);
            captured[i] = tdo_seen;
        end
        tck_step(1'b1, 1'b0, 1'b0, 1'b0);   // Update-IR
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Run-Test/Idle
        cur_instr = code;
    endtask

    task automatic dr_scan(input string name, input logic [31:0] tdi_bits,
                           input logic [31:0] ch_bits, output logic [31:0] tdo_bits);
        int i;
        tck_step(1'b1, 1'b0, 1'b0, 1'b0);   // Select-DR
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Capture-DR
        check_bit({name, " capture"}, 1'b1, ch_capture_o, scan_errors);
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Shift-DR
        check_bit({name, " shift"}, 1'b1, ch_shift_o, scan_errors);
        for (i = 0; i < 32; i++) begin
            tck_step(i == 31, tdi_bits[i], ch_bits[i], 1'b1);
            tdo_bits[i] = tdo_seen;
        end
        tck_step(1'b1, 1'b0, 1'b0, 1'b0);   // Update-DR
        check_bit({name, " update"}, 1'b1, ch_update_o, scan_errors);
        tck_step(1'b0, 1'b0, 1'b0, 1'b0);   // Run-Test/Idle
        check_bit({name, " idle strobes"}, 1'b0,
                  ch_capture_o | ch_shift_o | ch_update_o, scan_errors);
    endtask

    // Random TDI and chain data, scan-out against the model
    task automatic dr_check(input string name);
        logic [31:0] tdi_bits;
        logic [31:0] ch_bits;
        logic [31:0] got;
        tdi_bits = $random(seed);
        ch_bits  = $random(seed);
        dr_scan(name, tdi_bits, ch_bits, got);
        check_idcode(name, expected_dr_value(cur_instr, fuse_idcode_i, tdi_bits, ch_bits),
                     got, scan_errors);
    endtask

    task automatic chain_test(input string name, input tapc_pkg::tapc_ir_t code,
                              input logic dmi_exp, input logic scu_exp,
                              input tapc_pkg::tapc_ch_id_t id_exp);
        tapc_pkg::tapc_ir_t cap;
        ir_scan(code, cap);
        check_bit({name, " dmi_sel"}, dmi_exp, dmi_ch_sel_o, scan_errors);
        check_bit({name, " scu_sel"}, scu_exp, scu_ch_sel_o, scan_errors);
        check_ch_id({name, " ch_id"}, id_exp, ch_id_o, scan_errors);
        dr_check(name);
    endtask

    // ------------------------------------------------------------------
    // Pin checks on every rising edge
    // ------------------------------------------------------------------
    always @(posedge tapc_tck) begin
        if (tapc_trst_n) begin
            check_bit("tdo_en", exp_en, tdo_en_o, pin_errors);
            check_bit("ch_tdi", tdi_i, ch_tdi_o, pin_errors);
        end
    end

    always @(posedge tapc_tck) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d TCK cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        tapc_pkg::tapc_ir_t cap;
        tapc_trst_n   = 1'b0;
        tms_i         = 1'b1;
        tdi_i         = 1'b0;
        ch_tdo_i      = 1'b0;
        fuse_idcode_i = $random(seed);
        cur_instr     = `TAPC_INSTR_IDCODE;
        repeat (16) @(posedge tapc_tck);
        #1;
        tapc_trst_n = 1'b1;

        // Quiet pins out of reset
        check_bit("reset tdo", 1'b0, tdo_o, scan_errors);
        check_bit("reset strobes", 1'b0, ch_capture_o | ch_shift_o | ch_update_o, scan_errors);
        check_bit("reset chain sel", 1'b0, dmi_ch_sel_o | scu_ch_sel_o, scan_errors);
        reset_to_idle();

        // IDCODE is the default instruction
        dr_check("idcode after reset");

        ir_scan(`TAPC_INSTR_BYPASS, cap);
        check_ir("ir capture", 5'b00001, cap, scan_errors);
        dr_check("bypass");

        ir_scan(`TAPC_INSTR_BLD_ID, cap);
        dr_check("build id");

        chain_test("dtmcs", `TAPC_INSTR_DTMCS, 1'b1, 1'b0, `TAPC_CH_ID_DTMCS);
        chain_test("dmi access", `TAPC_INSTR_DMI_ACCESS, 1'b1, 1'b0, `TAPC_CH_ID_DMI);
        chain_test("scu access", `TAPC_INSTR_SCU_ACCESS, 1'b0, 1'b1, 2'd0);

        // Unused code falls back to bypass
        ir_scan(5'h00, cap);
        dr_check("unused code");

        // TMS reset path restores IDCODE
        reset_to_idle();
        dr_check("idcode after tlr");

        $display("Scan errors: %0d, pin errors: %0d", scan_errors, pin_errors);
        if (scan_errors + pin_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tapc.f
+incdir+common
common/tapc_pkg.sv
common/tapc_dr_ctrl_if.sv
source/tapc_dr_shift_reg.sv
tapc_fsm/tapc_fsm.sv
tapc_ir/tapc_ir.sv
source/tapc_dr_bank.sv
source/tapc.sv
sim/tapc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TAP controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tapc_tb -f tapc.f \
    --Mdir obj_dir -o tapc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tapc_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
